// File: vlog.f
source/ps2Pkg.sv
source/mousePkg.sv
source/ps2ByteIf.sv
source/ps2LineSampler.sv
source/ps2Transmitter.sv
source/ps2Receiver.sv
source/mouseReportUnit.sv
source/controlMouse.sv
sim/ps2MouseModel.sv
sim/tb_controlMouse.sv

// File: Bender.yml
package:
  name: control_mouse

sources:
  # Packages first, then the interface and the RTL
  - source/ps2Pkg.sv
  - source/mousePkg.sv
  - source/ps2ByteIf.sv
  - source/ps2LineSampler.sv
  - source/ps2Transmitter.sv
  - source/ps2Receiver.sv
  - source/mouseReportUnit.sv
  - source/controlMouse.sv
  - target: simulation
    files:
      - sim/ps2MouseModel.sv
      - sim/tb_controlMouse.sv

// File: sim/tb_controlMouse.sv
`timescale 1ns/1ps
`default_nettype none

module tb_controlMouse;

	import ps2Pkg::*;
	import mousePkg::*;

	localparam int FILTER_LEN         = 2;
	localparam int INHIBIT_CYCLES     = 20;
	localparam int ACK_TIMEOUT_CYCLES = 3000;
	localparam int HALF_PERIOD        = 40;
	localparam int RAND_SEED          = 82544;
	// Good and discarded packets over all scenarios
	localparam int PACKETS_SENT       = 37;
	localparam int BIT_CYCLES         = 2 * HALF_PERIOD;
	// Three command exchanges plus one ack timeout
	localparam int CMD_CYCLES = ACK_TIMEOUT_CYCLES +
		3 * (INHIBIT_CYCLES + 2 * FRAME_BITS * BIT_CYCLES);
	localparam int CYCLE_LIMIT = 2 *
		(PACKETS_SENT * PACKET_BYTES * FRAME_BITS * BIT_CYCLES + CMD_CYCLES);

	logic       Clk;
	logic       rst;
	wire        mouseClk;
	wire        mouseDat;
	logic       ready;
	logic       Click;
	logic       Izquierda;
	logic       Derecha;
	logic       Arriba;
	logic       Abajo;
	logic [7:0] MagX;
	logic [7:0] MagY;
	logic       packetValid;

	// Expected {Click, Izquierda, Derecha, Arriba, Abajo, MagX, MagY} in send order
	logic [20:0] expQ[$];
	int          cycleCount = 0;

	pullup (mouseClk);
	pullup (mouseDat);

	controlMouse #(
		.FILTER_LEN(FILTER_LEN),
		.INHIBIT_CYCLES(INHIBIT_CYCLES),
		.ACK_TIMEOUT_CYCLES(ACK_TIMEOUT_CYCLES)
	) controlMouse_i (
		.Clk(Clk), .rst(rst), .M_CLK(mouseClk), .M_Dat(mouseDat),
		.ready(ready), .Click(Click), .Izquierda(Izquierda), .Derecha(Derecha),
		.Arriba(Arriba), .Abajo(Abajo), .MagX(MagX), .MagY(MagY),
		.packetValid(packetValid)
	);

	ps2MouseModel #(
		.HALF_PERIOD(HALF_PERIOD)
	) mouseModel_i (
		.Clk(Clk), .psClk(mouseClk), .psDat(mouseDat)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	////////////////////////////////////////////////////////////////////////
	// Reference decode and checks
	////////////////////////////////////////////////////////////////////////

	function automatic logic [20:0] expectedDecode(input logic [7:0] status,
			input logic [7:0] xb, input logic [7:0] yb);
		int         dx;
		int         dy;
		logic [7:0] magX;
		logic [7:0] magY;
		// Nine-bit signed movement with its sign in the status byte
		dx = status[BIT_XSIGN] ? int'(xb) - 256 : int'(xb);
		dy = status[BIT_YSIGN] ? int'(yb) - 256 : int'(yb);
		dx = (dx < 0) ? -dx : dx;
		dy = (dy < 0) ? -dy : dy;
		magX = (status[BIT_XOVF] || dx > 255) ? 8'd255 : 8'(dx);
		magY = (status[BIT_YOVF] || dy > 255) ? 8'd255 : 8'(dy);
		return {status[BIT_LEFT] | status[BIT_RIGHT], status[BIT_XSIGN],
			~status[BIT_XSIGN], ~status[BIT_YSIGN], status[BIT_YSIGN], magX, magY};
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			abortRun("Stopping at the first mismatch");
		end
	endtask

	task automatic checkPacket(input logic [20:0] expected);
		checkValue("Click", Click, expected[20]);
		checkValue("Izquierda", Izquierda, expected[19]);
		checkValue("Derecha", Derecha, expected[18]);
		checkValue("Arriba", Arriba, expected[17]);
		checkValue("Abajo", Abajo, expected[16]);
		checkValue("MagX", MagX, expected[15:8]);
		checkValue("MagY", MagY, expected[7:0]);
	endtask

	// Decoded outputs are stable around the falling edge
	always @(negedge Clk) begin
		if (packetValid === 1'b1) begin
			if (expQ.size() == 0) begin
				abortRun("packetValid pulsed with no packet pending");
			end else begin
				checkPacket(expQ.pop_front());
			end
		end
	end

	always @(posedge Clk) begin
		cycleCount++;
		if (cycleCount == CYCLE_LIMIT) begin
			abortRun($sformatf("Timeout, run not finished after %0d cycles", CYCLE_LIMIT));
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////

	task automatic applyReset();
		@(negedge Clk);
		rst = 1'b1;
		repeat (2) @(negedge Clk);
		rst = 1'b0;
	endtask

	task automatic checkCommand();
		checkValue("command byte", mouseModel_i.lastCmd, CMD_ENABLE_REPORT);
		checkValue("command parity ok", mouseModel_i.lastParityOk, 1);
		checkValue("command stop ok", mouseModel_i.lastStopOk, 1);
	endtask

	// Model may still be in the gap after its 0xFA
	task automatic waitReady();
		wait (ready === 1'b1);
		wait (mouseModel_i.sending === 1'b0);
		@(negedge Clk);
	endtask

	task automatic sendPacket(input logic [7:0] status, input logic [7:0] xb,
			input logic [7:0] yb);
		expQ.push_back(expectedDecode(status, xb, yb));
		mouseModel_i.sendByte(status);
		mouseModel_i.sendByte(xb);
		mouseModel_i.sendByte(yb);
		checkValue("pending packets", expQ.size(), 0);
	endtask

	// Bit i of badByte gives byte i a bad parity bit
	task automatic sendDiscarded(input logic [7:0] status, input logic [7:0] xb,
			input logic [7:0] yb, input logic [2:0] badByte);
		logic [7:0] bytes [3];
		bytes = '{status, xb, yb};
		for (int i = 0; i < PACKET_BYTES; i++) begin
			if (badByte[i]) begin
				mouseModel_i.sendBadParity(bytes[i]);
			end else begin
				mouseModel_i.sendByte(bytes[i]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////
	// Scenarios
	////////////////////////////////////////////////////////////////////////

	initial begin : mainSequence
		int         resetCycle;
		int         cmdBase;
		int         ackBase;
		logic [7:0] status;
		void'($urandom(RAND_SEED));
		rst = 1'b1;
		applyReset();
		checkValue("ready", ready, 0);
		checkValue("packetValid", packetValid, 0);
		checkValue("Click", Click, 0);
		checkValue("Izquierda", Izquierda, 0);
		checkValue("Derecha", Derecha, 0);
		checkValue("Arriba", Arriba, 0);
		checkValue("Abajo", Abajo, 0);
		checkValue("MagX", MagX, 0);
		checkValue("MagY", MagY, 0);

		// Enable command and no ready before 0xFA
		wait (mouseModel_i.cmdCount == 1);
		@(negedge Clk);
		checkCommand();
		checkValue("ready", ready, 0);
		waitReady();
		checkValue("acks sent", mouseModel_i.ackCount, 1);

		// In-range random packets without overflow bits
		repeat (20) begin
			status = {2'b00, 2'($urandom()), 1'b1, 3'($urandom())};
			sendPacket(status, 8'($urandom()), 8'($urandom()));
		end

		// Signs, zero movement and buttons
		sendPacket(8'h38, 8'hF6, 8'h80);
		sendPacket(8'h08, 8'h00, 8'h00);
		checkValue("Derecha", Derecha, 1);
		checkValue("Arriba", Arriba, 1);
		sendPacket(8'h09, 8'h03, 8'h04);
		sendPacket(8'h0A, 8'h7F, 8'h01);
		// Middle button alone gives no Click
		sendPacket(8'h0C, 8'h02, 8'h02);

		// Saturation
		sendPacket(8'h48, 8'h10, 8'h05);
		sendPacket(8'hA8, 8'h00, 8'hF0);
		sendPacket(8'h38, 8'h00, 8'h00);
		checkValue("MagX", MagX, 255);
		checkValue("MagY", MagY, 255);
		sendPacket(8'h08, 8'hFF, 8'hFF);

		// Bad frames and lost alignment
		// Bytes that follow a dropped byte have bit 3 clear
		sendDiscarded(8'h09, 8'h10, 8'h21, 3'b001);
		sendPacket(8'h19, 8'h22, 8'h33);
		sendDiscarded(8'h0B, 8'h40, 8'h52, 3'b010);
		sendPacket(8'h2A, 8'h7F, 8'hC0);
		sendDiscarded(8'h28, 8'h11, 8'h7F, 3'b100);
		sendPacket(8'h3B, 8'h81, 8'h01);
		sendDiscarded(8'h01, 8'h05, 8'h02, 3'b000);
		sendPacket(8'h08, 8'h44, 8'h55);

		// First command goes unanswered and is resent after the timeout
		mouseModel_i.suppressAck = 1'b1;
		cmdBase = mouseModel_i.cmdCount;
		ackBase = mouseModel_i.ackCount;
		applyReset();
		resetCycle = cycleCount;
		wait (mouseModel_i.cmdCount == cmdBase + 1);
		@(negedge Clk);
		checkCommand();
		mouseModel_i.suppressAck = 1'b0;
		wait (mouseModel_i.cmdCount == cmdBase + 2);
		@(negedge Clk);
		checkCommand();
		checkValue("ready", ready, 0);
		checkValue("resend after timeout",
			(cycleCount - resetCycle) > ACK_TIMEOUT_CYCLES, 1);
		waitReady();
		checkValue("acks sent", mouseModel_i.ackCount, ackBase + 1);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/ps2MouseModel.sv
`timescale 1ns/1ps
`default_nettype none

module ps2MouseModel #(
	parameter int HALF_PERIOD = 40
) (
	input  logic Clk,
	inout  wire  psClk,
	inout  wire  psDat
);

	import ps2Pkg::*;

	// Open-drain pulls on the two lines
	logic       clkLow = 1'b0;
	logic       datLow = 1'b0;
	// Device frame in progress
	logic       sending = 1'b0;
	// Withholds the 0xFA answer when set
	logic       suppressAck = 1'b0;
	// Commands seen, answers started
	int         cmdCount = 0;
	int         ackCount = 0;
	logic [7:0] lastCmd = '0;
	logic       lastParityOk = 1'b0;
	logic       lastStopOk = 1'b0;

	assign psClk = clkLow ? 1'b0 : 1'bz;
	assign psDat = datLow ? 1'b0 : 1'bz;

	////////////////////////////////////////////////////////////////////////
	// Device to host
	////////////////////////////////////////////////////////////////////////

	task automatic sendFrame(input logic [7:0] data, input logic parityBit);
		logic [FRAME_BITS-1:0] bits;
		bits = {1'b1, parityBit, data, 1'b0};
		@(negedge Clk);
		sending = 1'b1;
		for (int i = 0; i < FRAME_BITS; i++) begin
			// Data set up half way through the high phase
			datLow = ~bits[i];
			repeat (HALF_PERIOD / 2) @(negedge Clk);
			clkLow = 1'b1;
			repeat (HALF_PERIOD) @(negedge Clk);
			clkLow = 1'b0;
			repeat (HALF_PERIOD / 2) @(negedge Clk);
		end
		datLow = 1'b0;
		// Idle gap before the next frame
		repeat (2 * HALF_PERIOD) @(negedge Clk);
		sending = 1'b0;
	endtask

	// Odd parity over data and parity bit
	task automatic sendByte(input logic [7:0] data);
		sendFrame(data, ~^data);
	endtask

	task automatic sendBadParity(input logic [7:0] data);
		sendFrame(data, ^data);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Host to device
	////////////////////////////////////////////////////////////////////////

	task automatic receiveCommand(output logic [7:0] data, output logic parityOk,
			output logic stopOk);
		logic [FRAME_BITS-2:0] bits;
		repeat (HALF_PERIOD) @(negedge Clk);
		// Data, parity, stop
		for (int i = 0; i < FRAME_BITS - 1; i++) begin
			clkLow = 1'b1;
			repeat (HALF_PERIOD) @(negedge Clk);
			// Read at the rising edge
			bits[i] = psDat;
			clkLow = 1'b0;
			repeat (HALF_PERIOD) @(negedge Clk);
		end
		// Ack bit, held over one more clock pulse
		datLow = 1'b1;
		repeat (HALF_PERIOD / 2) @(negedge Clk);
		clkLow = 1'b1;
		repeat (HALF_PERIOD) @(negedge Clk);
		clkLow = 1'b0;
		datLow = 1'b0;
		data     = bits[7:0];
		parityOk = ^bits[8:0];
		stopOk   = bits[9];
	endtask

	// Answers every request-to-send
	initial begin : serveCommands
		logic [7:0] rxByte;
		logic       parityOk;
		logic       stopOk;
		forever begin
			@(negedge Clk);
			// Clock released, data held low by the host
			if (!sending && !datLow && psClk === 1'b1 && psDat === 1'b0) begin
				receiveCommand(rxByte, parityOk, stopOk);
				lastCmd      = rxByte;
				lastParityOk = parityOk;
				lastStopOk   = stopOk;
				cmdCount++;
				if (!suppressAck) begin
					ackCount++;
					repeat (2 * HALF_PERIOD) @(negedge Clk);
					sendByte(ACK_BYTE);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/controlMouse.sv
`timescale 1ns/1ps
`default_nettype none

module controlMouse #(
	parameter int FILTER_LEN         = 8,
	parameter int INHIBIT_CYCLES     = 10000,
	parameter int ACK_TIMEOUT_CYCLES = 2000000
) (
	input  logic       Clk,
	input  logic       rst,
	inout  wire        M_CLK,
	inout  wire        M_Dat,
	output logic       ready,
	output logic       Click,
	output logic       Izquierda,
	output logic       Derecha,
	output logic       Arriba,
	output logic       Abajo,
	output logic [7:0] MagX,
	output logic [7:0] MagY,
	output logic       packetValid
);

	import ps2Pkg::*;

	logic              datLevel;
	logic              clkFall;
	logic              clkPullLow;
	logic              datPullLow;
	logic              busy;
	logic              sent;
	logic              ackOk;
	logic              send;
	mouseCmd_e         cmd;

	ps2ByteIf byteBus ();

	////////////////////////////////////////////////////////////////////////
	// Open-drain pads with external pull-ups for the high level
	////////////////////////////////////////////////////////////////////////

	assign M_CLK = clkPullLow ? 1'b0 : 1'bz;
	assign M_Dat = datPullLow ? 1'b0 : 1'bz;

	// Filtered clock level is only needed inside the sampler
	ps2LineSampler #(
		.FILTER_LEN(FILTER_LEN)
	) lineSampler_i (
		.Clk(Clk), .rst(rst), .psClk(M_CLK), .psDat(M_Dat),
		.clkLevel(), .datLevel(datLevel), .clkFall(clkFall)
	);

	ps2Transmitter #(
		.INHIBIT_CYCLES(INHIBIT_CYCLES)
	) transmitter_i (
		.Clk(Clk), .rst(rst), .send(send), .cmd(cmd),
		.clkFall(clkFall), .datLevel(datLevel),
		.clkPullLow(clkPullLow), .datPullLow(datPullLow),
		.busy(busy), .sent(sent), .ackOk(ackOk)
	);

	ps2Receiver receiver_i (
		.Clk(Clk), .rst(rst), .clkFall(clkFall), .datLevel(datLevel),
		.busy(busy), .byteBus(byteBus.rx)
	);

	mouseReportUnit #(
		.ACK_TIMEOUT_CYCLES(ACK_TIMEOUT_CYCLES)
	) reportUnit_i (
		.Clk(Clk), .rst(rst), .byteBus(byteBus.sink),
		.sent(sent), .ackOk(ackOk), .send(send), .cmd(cmd), .ready(ready),
		.Click(Click), .Izquierda(Izquierda), .Derecha(Derecha),
		.Arriba(Arriba), .Abajo(Abajo), .MagX(MagX), .MagY(MagY),
		.packetValid(packetValid)
	);

endmodule

`default_nettype wire

// File: source/mouseReportUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mouseReportUnit #(
	parameter int ACK_TIMEOUT_CYCLES = 2000000
) (
	input  logic              Clk,
	input  logic              rst,
	ps2ByteIf.sink            byteBus,
	input  logic              sent,
	input  logic              ackOk,
	output logic              send,
	output ps2Pkg::mouseCmd_e cmd,
	output logic              ready,
	output logic              Click,
	output logic              Izquierda,
	output logic              Derecha,
	output logic              Arriba,
	output logic              Abajo,
	output logic [7:0]        MagX,
	output logic [7:0]        MagY,
	output logic              packetValid
);

	import ps2Pkg::*;
	import mousePkg::*;

	localparam int TO_W = $clog2(ACK_TIMEOUT_CYCLES + 1);

	reportState_e    state;
	logic [TO_W-1:0] timeoutCnt;
	logic            byteErr;
	// Status and X bytes, Y is taken straight from the bus
	logic [7:0]      pkt [PACKET_BYTES-1];
	logic [8:0]      xMove;
	logic [8:0]      yMove;

	// Absolute value of a 9-bit movement, clamped
	function automatic logic [7:0] magnitude(input logic [8:0] move, input logic ovf);
		logic [8:0] absVal;
		absVal = move[8] ? (~move + 9'd1) : move;
		if (ovf || absVal[8]) begin
			return MAG_MAX;
		end
		return absVal[7:0];
	endfunction

	assign byteErr = byteBus.parityErr | byteBus.frameErr;
	assign xMove   = {pkt[0][BIT_XSIGN], pkt[1]};
	assign yMove   = {pkt[0][BIT_YSIGN], byteBus.data};
	assign send    = (state == SEND);
	assign cmd     = CMD_ENABLE_REPORT;

	////////////////////////////////////////////////////////////////////////
	// Startup and packet FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			state       <= SEND;
			timeoutCnt  <= '0;
			ready       <= 1'b0;
			packetValid <= 1'b0;
			Click       <= 1'b0;
			Izquierda   <= 1'b0;
			Derecha     <= 1'b0;
			Arriba      <= 1'b0;
			Abajo       <= 1'b0;
			MagX        <= '0;
			MagY        <= '0;
		end else begin
			packetValid <= 1'b0;
			case (state)
				SEND: begin
					timeoutCnt <= '0;
					state      <= WAITACK;
				end
				WAITACK: begin
					if (byteBus.valid && !byteErr && byteBus.data == ACK_BYTE) begin
						ready <= 1'b1;
						state <= BYTE0;
					end else if ((sent && !ackOk) ||
							timeoutCnt == TO_W'(ACK_TIMEOUT_CYCLES - 1)) begin
						// No ack bit or no answer, try again
						state <= SEND;
					end else begin
						timeoutCnt <= timeoutCnt + 1'b1;
					end
				end
				BYTE0: begin
					// Bit 3 marks a status byte
					if (byteBus.valid && !byteErr && byteBus.data[BIT_ALWAYS1]) begin
						state <= BYTE1;
					end
				end
				BYTE1: begin
					if (byteBus.valid) begin
						state <= byteErr ? BYTE0 : BYTE2;
					end
				end
				BYTE2: begin
					if (byteBus.valid) begin
						state <= BYTE0;
						if (!byteErr) begin
							packetValid <= 1'b1;
							Click       <= pkt[0][BIT_LEFT] | pkt[0][BIT_RIGHT];
							Izquierda   <= pkt[0][BIT_XSIGN];
							Derecha     <= ~pkt[0][BIT_XSIGN];
							Abajo       <= pkt[0][BIT_YSIGN];
							Arriba      <= ~pkt[0][BIT_YSIGN];
							MagX        <= magnitude(xMove, pkt[0][BIT_XOVF]);
							MagY        <= magnitude(yMove, pkt[0][BIT_YOVF]);
						end
					end
				end
				default: state <= SEND;
			endcase
		end
	end

	// Packet bytes held until the last one arrives
	always_ff @(posedge Clk) begin
		if (byteBus.valid && state == BYTE0) begin
			pkt[0] <= byteBus.data;
		end
		if (byteBus.valid && state == BYTE1) begin
			pkt[1] <= byteBus.data;
		end
	end

endmodule

`default_nettype wire

// File: source/ps2Receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2Receiver (
	input  logic Clk,
	input  logic rst,
	input  logic clkFall,
	input  logic datLevel,
	input  logic busy,
	ps2ByteIf.rx byteBus
);

	import ps2Pkg::*;

	rxState_e              state;
	// Bits taken so far, start bit included
	logic [3:0]            bitCnt;
	// Start at bit 0, stop at the top after a full frame
	logic [FRAME_BITS-1:0] frame;

	////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			state  <= RX_IDLE;
			bitCnt <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					// Start bit fall, ignored while sending
					if (clkFall && !busy) begin
						bitCnt <= 4'd1;
						state  <= RX_SHIFT;
					end
				end
				RX_SHIFT: begin
					if (busy) begin
						// Host took the bus, drop the partial frame
						state <= RX_IDLE;
					end else if (clkFall) begin
						if (bitCnt == 4'(FRAME_BITS - 1)) begin
							state <= RX_CHECK;
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end
				end
				RX_CHECK: state <= RX_IDLE;
				default:  state <= RX_IDLE;
			endcase
		end
	end

	// LSB first, new bit enters at the top
	always_ff @(posedge Clk) begin
		if (clkFall && !busy && state != RX_CHECK) begin
			frame <= {datLevel, frame[FRAME_BITS-1:1]};
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Byte out, held steady in the check cycle
	////////////////////////////////////////////////////////////////////////

	assign byteBus.valid     = (state == RX_CHECK);
	assign byteBus.data      = frame[8:1];
	// Data plus parity must hold an odd count of ones
	assign byteBus.parityErr = ~(^frame[9:1]);
	assign byteBus.frameErr  = frame[0] | ~frame[FRAME_BITS-1];

endmodule

`default_nettype wire

// File: source/ps2Transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module ps2Transmitter #(
	parameter int INHIBIT_CYCLES = 10000
) (
	input  logic              Clk,
	input  logic              rst,
	input  logic              send,
	input  ps2Pkg::mouseCmd_e cmd,
	input  logic              clkFall,
	input  logic              datLevel,
	output logic              clkPullLow,
	output logic              datPullLow,
	output logic              busy,
	output logic              sent,
	output logic              ackOk
);

	import ps2Pkg::*;

	localparam int INH_W = $clog2(INHIBIT_CYCLES + 1);

	txState_e         state;
	logic [INH_W-1:0] inhibitCnt;
	logic [3:0]       bitCnt;
	// Data LSB first, parity, then a 1 so the stop slot releases the line
	logic [9:0]       shiftReg;

	////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			state      <= TX_IDLE;
			inhibitCnt <= '0;
			bitCnt     <= '0;
			clkPullLow <= 1'b0;
			datPullLow <= 1'b0;
			ackOk      <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (send) begin
						// Inhibit the device clock
						clkPullLow <= 1'b1;
						inhibitCnt <= '0;
						state      <= TX_INHIBIT;
					end
				end
				TX_INHIBIT: begin
					if (inhibitCnt == INH_W'(INHIBIT_CYCLES - 1)) begin
						// Start bit
						datPullLow <= 1'b1;
						state      <= TX_REQUEST;
					end else begin
						inhibitCnt <= inhibitCnt + 1'b1;
					end
				end
				TX_REQUEST: begin
					// Hand the clock back, device starts clocking
					clkPullLow <= 1'b0;
					bitCnt     <= '0;
					state      <= TX_SHIFT;
				end
				TX_SHIFT: begin
					if (clkFall) begin
						datPullLow <= ~shiftReg[0];
						if (bitCnt == 4'(FRAME_BITS - 2)) begin
							state <= TX_ACKBIT;
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end
				end
				TX_ACKBIT: begin
					// Device pulls data low to acknowledge
					if (clkFall) begin
						ackOk <= ~datLevel;
						state <= TX_DONE;
					end
				end
				TX_DONE: state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Frame payload, loaded on send
	always_ff @(posedge Clk) begin
		if (state == TX_IDLE && send) begin
			shiftReg <= {1'b1, ~^cmd, cmd};
		end else if (state == TX_SHIFT && clkFall) begin
			shiftReg <= shiftReg >> 1;
		end
	end

	assign busy = (state != TX_IDLE);
	// One cycle after the ack slot
	assign sent = (state == TX_DONE);

endmodule

`default_nettype wire

// File: source/ps2LineSampler.sv
`timescale 1ns/1ps
`default_nettype none

module ps2LineSampler #(
	parameter int FILTER_LEN = 8
) (
	input  logic Clk,
	input  logic rst,
	input  logic psClk,
	input  logic psDat,
	output logic clkLevel,
	output logic datLevel,
	output logic clkFall
);

	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	// Index 0 is the clock line, index 1 the data line
	logic [1:0] pinIn;
	logic [1:0] lineLevel;
	// Filtered clock one cycle back
	logic       clkPrev;

	assign pinIn = {psDat, psClk};

	////////////////////////////////////////////////////////////////////////
	// Synchronizer and glitch filter, one per line
	////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : gLine
		logic [1:0]       syncQ;
		logic [CNT_W-1:0] stableCnt;

		always_ff @(posedge Clk) begin
			if (rst) begin
				// Idle bus is high
				syncQ        <= 2'b11;
				stableCnt    <= '0;
				lineLevel[i] <= 1'b1;
			end else begin
				syncQ <= {syncQ[0], pinIn[i]};
				if (syncQ[1] == lineLevel[i]) begin
					// Same as accepted level, restart count
					stableCnt <= '0;
				end else if (stableCnt == CNT_W'(FILTER_LEN - 1)) begin
					lineLevel[i] <= syncQ[1];
					stableCnt    <= '0;
				end else begin
					stableCnt <= stableCnt + 1'b1;
				end
			end
		end
	end

	// Edge detect on the filtered clock
	always_ff @(posedge Clk) begin
		if (rst) begin
			clkPrev <= 1'b1;
		end else begin
			clkPrev <= lineLevel[0];
		end
	end

	assign clkLevel = lineLevel[0];
	assign datLevel = lineLevel[1];
	// High to low of the device clock
	assign clkFall  = clkPrev & ~clkLevel;

endmodule

`default_nettype wire

// File: source/ps2ByteIf.sv
`timescale 1ns/1ps
`default_nettype none

// Received byte from the deserializer to the packet logic
// No back-pressure, sink takes the byte in the valid cycle
interface ps2ByteIf;

	// Data bits of the frame
	logic [7:0] data;
	// One-cycle strobe
	logic       valid;
	// Odd parity not met
	logic       parityErr;
	// Bad start or stop bit
	logic       frameErr;

	// Deserializer side
	modport rx (
		output data, valid, parityErr, frameErr
	);

	// Packet logic side
	modport sink (
		input data, valid, parityErr, frameErr
	);

endinterface

`default_nettype wire

// File: source/mousePkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Mouse movement packet format
////////////////////////////////////////////////////////////////////////////

package mousePkg;

	// Status byte, X movement, Y movement
	localparam int PACKET_BYTES = 3;

	// Bit positions inside the status byte
	localparam int BIT_LEFT    = 0;
	localparam int BIT_RIGHT   = 1;
	localparam int BIT_ALWAYS1 = 3;
	localparam int BIT_XSIGN   = 4;
	localparam int BIT_YSIGN   = 5;
	localparam int BIT_XOVF    = 6;
	localparam int BIT_YOVF    = 7;

	// Magnitude clamp for overflow and -256
	localparam logic [7:0] MAG_MAX = 8'd255;

	// Startup, then packet assembly
	typedef enum logic [2:0] {
		SEND,
		WAITACK,
		BYTE0,
		BYTE1,
		BYTE2
	} reportState_e;

endpackage

`default_nettype wire

// File: source/ps2Pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// PS/2 line protocol definitions
////////////////////////////////////////////////////////////////////////////

package ps2Pkg;

	// Start, 8 data bits, odd parity, stop
	localparam int FRAME_BITS = 11;

	// Commands the host may send to the mouse
	typedef enum logic [7:0] {
		CMD_ENABLE_REPORT = 8'hF4
	} mouseCmd_e;

	// Device answer to any accepted command
	localparam logic [7:0] ACK_BYTE = 8'hFA;

	// Host to device sender
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_INHIBIT,
		TX_REQUEST,
		TX_SHIFT,
		TX_ACKBIT,
		TX_DONE
	} txState_e;

	// Device to host deserializer
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_SHIFT,
		RX_CHECK
	} rxState_e;

endpackage

`default_nettype wire
